//--- dataMemUnit.f
+incdir+design
design/memOpPkg.sv
design/memBusPkg.sv
design/storeAlign.sv
design/dataMem.sv
design/loadExtend.sv
design/dataMemUnit.sv
verif/dataMemUnitTb.sv

//--- runSim.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --top-module dataMemUnitTb -f dataMemUnit.f -o simv > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1 \
	|| echo "simulator exited with an error status"

grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, run ended without a result, see sim.log"; exit 1; }

//--- verif/dataMemUnitTb.sv
// Testbench for the data-memory stage, stops at the first mismatch.
// The RAM has no reset, so every word is written with SW stores before any load.
// Expected load data comes from a byte-array model of the big-endian memory.
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMemUnitTb;

	localparam int AW             = `DM_ADDR_WIDTH;
	localparam int NUM_BYTES      = `DM_WORDS * 4;
	localparam int NUM_WORD_TEST  = 3;
	localparam int NUM_LANE_TEST  = 12;
	localparam int NUM_EXT_TEST   = 11;
	localparam int NUM_REV_TEST   = 6;
	localparam int NUM_RANDOM     = 400;
	localparam int NUM_REQUESTS   = `DM_WORDS + NUM_WORD_TEST + NUM_LANE_TEST
		+ NUM_EXT_TEST + NUM_REV_TEST + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = 2 * NUM_REQUESTS + 100;

	logic                clk;
	logic                rstN;
	memBusPkg::memReq_t  req;
	memBusPkg::memResp_t resp;

	logic [7:0]          refMem [NUM_BYTES]; // byte 0 of a word at the lowest address
	memBusPkg::memResp_t expQ[$];
	int                  dueQ[$];             // cycle in which the response is expected
	string               nameQ[$];
	int                  cycleCnt = 0;
	int                  seed;

	dataMemUnit i_dataMemUnit (
		.clk  (clk),
		.rstN (rstN),
		.req  (req),
		.resp (resp)
	);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES) begin
			abortRun($sformatf("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	function automatic logic [AW-1:0] byteAddr(input int word, input logic [1:0] lane);
		return {word[AW-3:0], lane};
	endfunction

	// spreads the whole word index over all 32 bits
	function automatic logic [31:0] fillWord(input int word);
		logic [31:0] wv;
		wv = word;
		return (wv * 32'h9e3779b1) ^ 32'h5bd1e995;
	endfunction

	function automatic logic isLoadOp(input memOpPkg::memOp_t op);
		case (op)
			memOpPkg::MEM_LW,
			memOpPkg::MEM_LWBR,
			memOpPkg::MEM_LH,
			memOpPkg::MEM_LHBR,
			memOpPkg::MEM_LHA,
			memOpPkg::MEM_LB: return 1'b1;
			default:          return 1'b0;
		endcase
	endfunction

	function automatic void storeRef(input memOpPkg::memOp_t op, input logic [AW-1:0] addr,
			input logic [31:0] wdata);
		case (op)
			memOpPkg::MEM_SW: begin
				refMem[{addr[AW-1:2], 2'd0}] = wdata[31:24];
				refMem[{addr[AW-1:2], 2'd1}] = wdata[23:16];
				refMem[{addr[AW-1:2], 2'd2}] = wdata[15:8];
				refMem[{addr[AW-1:2], 2'd3}] = wdata[7:0];
			end
			memOpPkg::MEM_SWBR: begin
				refMem[{addr[AW-1:2], 2'd0}] = wdata[7:0];
				refMem[{addr[AW-1:2], 2'd1}] = wdata[15:8];
				refMem[{addr[AW-1:2], 2'd2}] = wdata[23:16];
				refMem[{addr[AW-1:2], 2'd3}] = wdata[31:24];
			end
			memOpPkg::MEM_SH: begin
				refMem[{addr[AW-1:1], 1'b0}] = wdata[15:8];
				refMem[{addr[AW-1:1], 1'b1}] = wdata[7:0];
			end
			memOpPkg::MEM_SHBR: begin
				refMem[{addr[AW-1:1], 1'b0}] = wdata[7:0];
				refMem[{addr[AW-1:1], 1'b1}] = wdata[15:8];
			end
			memOpPkg::MEM_SB: begin
				refMem[addr] = wdata[7:0];
			end
			default: ; // loads and NOP leave memory alone
		endcase
	endfunction

	function automatic logic [31:0] loadRef(input memOpPkg::memOp_t op, input logic [AW-1:0] addr);
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] hHi;
		logic [7:0] hLo;
		b0  = refMem[{addr[AW-1:2], 2'd0}];
		b1  = refMem[{addr[AW-1:2], 2'd1}];
		b2  = refMem[{addr[AW-1:2], 2'd2}];
		b3  = refMem[{addr[AW-1:2], 2'd3}];
		hHi = refMem[{addr[AW-1:1], 1'b0}]; // bit 0 ignored for halfwords
		hLo = refMem[{addr[AW-1:1], 1'b1}];
		case (op)
			memOpPkg::MEM_LW:   return {b0, b1, b2, b3};
			memOpPkg::MEM_LWBR: return {b3, b2, b1, b0};
			memOpPkg::MEM_LH:   return {16'h0000, hHi, hLo};
			memOpPkg::MEM_LHBR: return {16'h0000, hLo, hHi};
			memOpPkg::MEM_LHA:  return {{16{hHi[7]}}, hHi, hLo};
			memOpPkg::MEM_LB:   return {24'h000000, refMem[addr]};
			default:            return 32'h00000000;
		endcase
	endfunction

	task automatic checkResp(input string name, input memBusPkg::memResp_t expResp,
			input memBusPkg::memResp_t actResp);
		if (actResp.valid !== expResp.valid) begin
			abortRun($sformatf("error: test %s expected valid %b actual valid %b",
				name, expResp.valid, actResp.valid));
		end else if (expResp.valid && actResp.data !== expResp.data) begin
			abortRun($sformatf("error: test %s expected %08h actual %08h",
				name, expResp.data, actResp.data));
		end
	endtask

	// drives one request for one cycle and updates the model
	task automatic issueReq(input string name, input logic valid, input memOpPkg::memOp_t op,
			input logic [AW-1:0] addr, input logic [31:0] wdata);
		memBusPkg::memResp_t expResp;
		req.valid = valid;
		req.op    = op;
		req.addr  = addr;
		req.wdata = wdata;
		if (valid && isLoadOp(op)) begin
			expResp.valid = 1'b1;
			expResp.data  = loadRef(op, addr);
			expQ.push_back(expResp);
			dueQ.push_back(cycleCnt + 1);
			nameQ.push_back(name);
		end else if (valid) begin
			storeRef(op, addr, wdata);
		end
		@(negedge clk);
	endtask

	task automatic idleCycles(input int n);
		req.valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// responses are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		string               name;
		memBusPkg::memResp_t expResp;
		int                  due;
		if (resp.valid === 1'b1) begin
			if (expQ.size() == 0) begin
				abortRun("resp.valid is high but no load is pending");
			end else begin
				name    = nameQ.pop_front();
				expResp = expQ.pop_front();
				due     = dueQ.pop_front();
				if (due != cycleCnt) begin
					abortRun($sformatf("response for test %s came in cycle %0d, due in cycle %0d",
						name, cycleCnt, due));
				end else begin
					checkResp(name, expResp, resp);
				end
			end
		end else if (dueQ.size() != 0 && dueQ[0] <= cycleCnt) begin
			abortRun($sformatf("load of test %s got no response in cycle %0d", nameQ[0], dueQ[0]));
		end
	end

	initial begin
		logic [AW-1:0]    a;
		logic [31:0]      d;
		logic             v;
		int               opIdx;
		memOpPkg::memOp_t op;
		seed = 32'hb597c305;
		rstN = 1'b0;
		req  = '0;
		// a valid load held in reset must give no response
		req.valid = 1'b1;
		req.op    = memOpPkg::MEM_LW;
		repeat (8) begin
			@(negedge clk);
			checkResp("reset", '0, resp);
		end
		rstN = 1'b1;
		req  = '0;
		@(negedge clk);
		checkResp("reset", '0, resp); // first cycle out of reset

		for (int w = 0; w < `DM_WORDS; w++) begin
			issueReq("preload", 1'b1, memOpPkg::MEM_SW, byteAddr(w, 2'd0), fillWord(w));
		end

		issueReq("word", 1'b1, memOpPkg::MEM_SW, byteAddr(17, 2'd0), 32'h12345678);
		issueReq("word", 1'b1, memOpPkg::MEM_LW, byteAddr(17, 2'd0), 32'h0);
		issueReq("word", 1'b1, memOpPkg::MEM_LWBR, byteAddr(17, 2'd3), 32'h0);
		idleCycles(2);

		for (int h = 0; h < 2; h++) begin
			issueReq("half lane", 1'b1, memOpPkg::MEM_SH, byteAddr(40, {h[0], 1'b0}),
				{16'h7777, 8'hc0, 8'h01 + h[7:0]});
			issueReq("half lane", 1'b1, memOpPkg::MEM_LW, byteAddr(40, 2'd0), 32'h0);
		end
		for (int l = 0; l < 4; l++) begin
			issueReq("byte lane", 1'b1, memOpPkg::MEM_SB, byteAddr(41, l[1:0]),
				{24'hffffff, 8'h10 + l[7:0]});
			issueReq("byte lane", 1'b1, memOpPkg::MEM_LW, byteAddr(41, 2'd0), 32'h0);
		end
		idleCycles(2);

		issueReq("extend", 1'b1, memOpPkg::MEM_SW, byteAddr(60, 2'd0), 32'hb1c2f3d4);
		for (int h = 0; h < 2; h++) begin
			issueReq("extend lh", 1'b1, memOpPkg::MEM_LH, byteAddr(60, {h[0], 1'b1}), 32'h0);
			issueReq("extend lhbr", 1'b1, memOpPkg::MEM_LHBR, byteAddr(60, {h[0], 1'b1}), 32'h0);
			issueReq("extend lha", 1'b1, memOpPkg::MEM_LHA, byteAddr(60, {h[0], 1'b1}), 32'h0);
		end
		for (int l = 0; l < 4; l++) begin
			issueReq("extend lb", 1'b1, memOpPkg::MEM_LB, byteAddr(60, l[1:0]), 32'h0);
		end
		idleCycles(2);

		for (int h = 0; h < 2; h++) begin
			issueReq("reversed", 1'b1, memOpPkg::MEM_SHBR, byteAddr(80, {h[0], 1'b0}),
				{16'h0000, 8'h9a + h[7:0], 8'h3e});
			issueReq("reversed", 1'b1, memOpPkg::MEM_LW, byteAddr(80, 2'd0), 32'h0);
		end
		issueReq("reversed", 1'b1, memOpPkg::MEM_SWBR, byteAddr(81, 2'd0), 32'h0a1b2c3d);
		issueReq("reversed", 1'b1, memOpPkg::MEM_LW, byteAddr(81, 2'd0), 32'h0);
		idleCycles(2);

		// back to back, about one request in eight not valid
		for (int n = 0; n < NUM_RANDOM; n++) begin
			opIdx = $unsigned($random(seed)) % 12;
			op    = memOpPkg::memOp_t'(opIdx[3:0]);
			v     = (($random(seed) & 32'd7) != 0);
			d     = $random(seed);
			a     = d[AW-1:0];
			d     = $random(seed);
			issueReq("random", v, op, a, d);
		end
		idleCycles(3);

		if (expQ.size() != 0) begin
			$display("%0d load responses never arrived", expQ.size());
			$display("Simulation failed");
			$fatal(1, "responses missing");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- design/dataMemUnit.sv
// Data-memory stage top: store alignment, RAM and load extension.
// One request per cycle; loads answer exactly one cycle later, stores
// and NOPs give no response. No back-pressure.
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMemUnit (
	input  logic                clk,
	input  logic                rstN,
	input  memBusPkg::memReq_t  req,
	output memBusPkg::memResp_t resp
);

	memBusPkg::ramWrite_t      ramWr;
	logic [`DM_ADDR_WIDTH-3:0] rdAddr;
	logic [31:0]               rdWord;

	assign rdAddr = req.addr[`DM_ADDR_WIDTH-1:2]; // word index

	// store path
	storeAlign i_storeAlign (
		.req   (req),
		.ramWr (ramWr)
	);

	// write on the sampling edge, read registered on the same edge
	dataMem i_dataMem (
		.clk    (clk),
		.ramWr  (ramWr),
		.rdAddr (rdAddr),
		.rdWord (rdWord)
	);

	// load path
	loadExtend i_loadExtend (
		.clk    (clk),
		.rstN   (rstN),
		.req    (req),
		.rdWord (rdWord),
		.resp   (resp)
	);

endmodule

//--- design/loadExtend.sv
// Load context register and lane extraction.
// Context is captured on the same edge as the RAM read, so resp lines up
// with rdWord exactly one cycle after the request.
// Halfword loads use only addr[1]; word loads ignore addr[1:0].
`timescale 1ns/1ps

module loadExtend (
	input  logic                clk,
	input  logic                rstN,
	input  memBusPkg::memReq_t  req,
	input  logic [31:0]         rdWord,
	output memBusPkg::memResp_t resp
);

	logic             isLoad;
	logic             loadValid;
	memOpPkg::memOp_t loadOp;
	logic [1:0]       loadLane;
	logic [15:0]      selHalf;
	logic [7:0]       selByte;

	always_comb begin
		case (req.op)
			memOpPkg::MEM_LW,
			memOpPkg::MEM_LWBR,
			memOpPkg::MEM_LH,
			memOpPkg::MEM_LHBR,
			memOpPkg::MEM_LHA,
			memOpPkg::MEM_LB: isLoad = 1'b1;
			default:          isLoad = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			loadValid <= 1'b0;
		end else begin
			loadValid <= req.valid && isLoad; // one pulse per load
		end
	end

	// payload only, qualified by loadValid
	always_ff @(posedge clk) begin
		loadOp   <= req.op;
		loadLane <= req.addr[1:0];
	end

	assign selHalf = loadLane[1] ? rdWord[15:0] : rdWord[31:16];

	always_comb begin
		case (loadLane)
			2'd0:    selByte = rdWord[31:24]; // msb lane
			2'd1:    selByte = rdWord[23:16];
			2'd2:    selByte = rdWord[15:8];
			default: selByte = rdWord[7:0];
		endcase
	end

	always_comb begin
		resp.valid = loadValid;
		case (loadOp)
			memOpPkg::MEM_LW: begin
				resp.data = rdWord;
			end
			memOpPkg::MEM_LWBR: begin
				resp.data = {rdWord[7:0], rdWord[15:8], rdWord[23:16], rdWord[31:24]};
			end
			memOpPkg::MEM_LH: begin
				resp.data = {16'h0000, selHalf};
			end
			memOpPkg::MEM_LHBR: begin
				resp.data = {16'h0000, selHalf[7:0], selHalf[15:8]};
			end
			memOpPkg::MEM_LHA: begin
				resp.data = {{16{selHalf[15]}}, selHalf};
			end
			memOpPkg::MEM_LB: begin
				resp.data = {24'h000000, selByte};
			end
			default: begin
				resp.data = rdWord; // no response, value unused
			end
		endcase
	end

endmodule

//--- design/dataMem.sv
// Word-wide data RAM with byte-lane writes and a registered read.
// The read port samples rdAddr every cycle, like a block RAM.
// A read and a write of the same word on one edge return the old word.
// The array has no reset, so contents start undefined.
`timescale 1ns/1ps
`include "dataMem_config.svh"

module dataMem (
	input  logic                      clk,
	input  memBusPkg::ramWrite_t      ramWr,
	input  logic [`DM_ADDR_WIDTH-3:0] rdAddr,
	output logic [31:0]               rdWord
);

	logic [31:0] memArray [`DM_WORDS];

	// be[i] covers bits i*8+7 .. i*8, so be[3] is byte 0
	always_ff @(posedge clk) begin
		if (ramWr.we) begin
			for (int i = 0; i < 4; i++) begin
				if (ramWr.be[i]) begin
					memArray[ramWr.wordAddr][i*8 +: 8] <= ramWr.data[i*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		rdWord <= memArray[rdAddr]; // data valid the cycle after the address
	end

endmodule

//--- design/storeAlign.sv
// Store alignment, purely combinational.
// Halfword stores look only at addr[1]; word stores ignore addr[1:0].
// Misaligned addresses are not detected.
`timescale 1ns/1ps
`include "dataMem_config.svh"

module storeAlign (
	input  memBusPkg::memReq_t   req,
	output memBusPkg::ramWrite_t ramWr
);

	logic [7:0]  lowByte;
	logic [15:0] lowHalf;
	logic [15:0] swapHalf;
	logic [31:0] revWord;
	logic [1:0]  lane;
	logic        isStore;

	assign lowByte  = req.wdata[7:0];
	assign lowHalf  = req.wdata[15:0];
	assign swapHalf = {req.wdata[7:0], req.wdata[15:8]};
	assign revWord  = {req.wdata[7:0], req.wdata[15:8], req.wdata[23:16], req.wdata[31:24]};
	assign lane     = req.addr[1:0]; // 0 is the msb lane

	always_comb begin
		case (req.op)
			memOpPkg::MEM_SW,
			memOpPkg::MEM_SH,
			memOpPkg::MEM_SB,
			memOpPkg::MEM_SHBR,
			memOpPkg::MEM_SWBR: isStore = 1'b1;
			default:            isStore = 1'b0;
		endcase
	end

	// lane data and enables
	always_comb begin
		ramWr.we       = req.valid && isStore;
		ramWr.wordAddr = req.addr[`DM_ADDR_WIDTH-1:2];
		ramWr.data     = req.wdata;
		ramWr.be       = 4'b0000;
		case (req.op)
			memOpPkg::MEM_SW: begin
				ramWr.be = 4'b1111;
			end
			memOpPkg::MEM_SWBR: begin
				ramWr.data = revWord;
				ramWr.be   = 4'b1111;
			end
			memOpPkg::MEM_SH: begin
				ramWr.data = {2{lowHalf}};
				ramWr.be   = lane[1] ? 4'b0011 : 4'b1100;
			end
			memOpPkg::MEM_SHBR: begin
				ramWr.data = {2{swapHalf}}; // swap before replicating
				ramWr.be   = lane[1] ? 4'b0011 : 4'b1100;
			end
			memOpPkg::MEM_SB: begin
				ramWr.data = {4{lowByte}};
				case (lane)
					2'd0:    ramWr.be = 4'b1000;
					2'd1:    ramWr.be = 4'b0100;
					2'd2:    ramWr.be = 4'b0010;
					default: ramWr.be = 4'b0001;
				endcase
			end
			default: begin
				ramWr.be = 4'b0000; // loads and NOP write nothing
			end
		endcase
	end

endmodule

//--- design/memBusPkg.sv
// Request, response and RAM write-port structs.
// Address fields are byte addresses; the word index is addr[DM_ADDR_WIDTH-1:2].
// No handshake: valid is a plain one-cycle strobe.
`include "dataMem_config.svh"

package memBusPkg;

	// one memory request per cycle
	typedef struct packed {
		logic                      valid;
		memOpPkg::memOp_t          op;
		logic [`DM_ADDR_WIDTH-1:0] addr;  // byte address
		logic [31:0]               wdata; // store data, low bits used for SH/SB
	} memReq_t;

	// load result, one cycle after the request
	typedef struct packed {
		logic        valid;
		logic [31:0] data;
	} memResp_t;

	// byte-lane write port into the RAM
	typedef struct packed {
		logic                      we;
		memOpPkg::byteEn_t         be;
		logic [`DM_ADDR_WIDTH-3:0] wordAddr;
		logic [31:0]               data; // already lane-replicated
	} ramWrite_t;

endpackage

//--- design/memOpPkg.sv
// Opcodes and lane mask of the data-memory stage.
// Big-endian only: byte 0 is the most significant byte of a word.
package memOpPkg;

	// request opcode, NOP and stores before loads
	typedef enum logic [3:0] {
		MEM_NOP  = 4'd0,
		MEM_SW   = 4'd1,
		MEM_SH   = 4'd2,
		MEM_SB   = 4'd3,
		MEM_SHBR = 4'd4,  // halfword, bytes swapped
		MEM_SWBR = 4'd5,  // word, bytes reversed
		MEM_LW   = 4'd6,
		MEM_LWBR = 4'd7,
		MEM_LH   = 4'd8,  // zero-extended
		MEM_LHBR = 4'd9,
		MEM_LHA  = 4'd10, // sign-extended
		MEM_LB   = 4'd11  // zero-extended
	} memOp_t;

	// one bit per byte lane
	// bit 3 is byte 0 (bits 31:24), bit 0 is byte 3 (bits 7:0)
	typedef logic [3:0] byteEn_t;

endpackage

//--- design/dataMem_config.svh
// Memory sizing for the data-memory stage.
// DM_ADDR_WIDTH must equal log2(DM_WORDS) + 2 because addresses are byte addresses.
// Only power-of-two depths are supported.
`ifndef DATAMEM_CONFIG_SVH
`define DATAMEM_CONFIG_SVH

// number of 32-bit words
`define DM_WORDS 256

// byte-address width, two bits above the word index
`define DM_ADDR_WIDTH 10

`endif
